// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= id_stage_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
PASS_MSG  := SIMULATION PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: hw/id_ex_register.sv
/*
  ID/EX pipeline register and stage ready.
  Bubbles only clear instr_valid; the rest of the record keeps its old value.
*/
module id_ex_register (
  input  logic                          clk,
  input  logic                          rst_n,
  input  id_pipe_pkg::if_id_t           if_id_i,
  input  id_pipe_pkg::ctrl_fsm_t        ctrl_fsm_i,
  input  logic                          ex_ready_i,
  input  id_pipe_pkg::decode_t          dec_i,
  input  logic [rv_isa_pkg::XLEN-1:0]   alu_operand_a_i,
  input  logic [rv_isa_pkg::XLEN-1:0]   alu_operand_b_i,
  input  logic [rv_isa_pkg::XLEN-1:0]   operand_c_i,
  output id_pipe_pkg::id_ex_t           id_ex_o,
  output logic                          id_ready_o
);

  logic instr_valid;

  // Halt and kill both turn the instruction in ID into a bubble
  assign instr_valid = if_id_i.instr_valid && !ctrl_fsm_i.halt_id && !ctrl_fsm_i.kill_id;

  // Kill flushes ID, so it frees the stage even under back-pressure
  assign id_ready_o = ctrl_fsm_i.kill_id || (ex_ready_i && !ctrl_fsm_i.halt_id);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_ex_o <= '0;
    end else if (ex_ready_i) begin
      if (instr_valid) begin
        id_ex_o.instr_valid   <= 1'b1;
        id_ex_o.alu_en        <= dec_i.alu_en;
        id_ex_o.alu_op        <= dec_i.alu_op;
        id_ex_o.alu_operand_a <= alu_operand_a_i;
        id_ex_o.alu_operand_b <= alu_operand_b_i;
        id_ex_o.operand_c     <= operand_c_i;
        id_ex_o.rf_we         <= dec_i.rf_we;
        id_ex_o.rf_waddr      <= dec_i.rf_waddr;
        id_ex_o.lsu_en        <= dec_i.lsu_en;
        id_ex_o.lsu_we        <= dec_i.lsu_we;
        id_ex_o.lsu_size      <= dec_i.lsu_size;
        id_ex_o.lsu_sign_ext  <= dec_i.lsu_sign_ext;
        id_ex_o.branch_in_ex  <= dec_i.is_branch;
        id_ex_o.illegal_insn  <= dec_i.illegal_insn;
        id_ex_o.pc            <= if_id_i.pc;
      end else begin
        id_ex_o.instr_valid   <= 1'b0;
      end
    end
  end

endmodule

// File: hw/id_pipe_pkg.sv
/*
  Pipeline records around the decode stage.
  Depends on rv_isa_pkg, which must be compiled first.
*/
package id_pipe_pkg;

  // Source of an operand, set by the controller's hazard logic
  typedef enum logic [1:0] {REGFILE, FW_EX, FW_WB} fw_sel_e;

  typedef struct packed {
    fw_sel_e operand_a_sel;
    fw_sel_e operand_b_sel;
  } byp_ctrl_t;

  typedef struct packed {
    logic halt_id;
    logic kill_id;
  } ctrl_fsm_t;

  ////////////////////////////////////////
  // IF/ID and ID/EX records
  ////////////////////////////////////////
  typedef struct packed {
    logic                            instr_valid;
    logic [rv_isa_pkg::XLEN-1:0]     pc;
    logic [31:0]                     instr;
  } if_id_t;

  typedef struct packed {
    logic                            instr_valid;
    logic                            alu_en;
    rv_isa_pkg::alu_op_e             alu_op;
    logic [rv_isa_pkg::XLEN-1:0]     alu_operand_a;
    logic [rv_isa_pkg::XLEN-1:0]     alu_operand_b;
    logic [rv_isa_pkg::XLEN-1:0]     operand_c;
    logic                            rf_we;
    rv_isa_pkg::reg_addr_t           rf_waddr;
    logic                            lsu_en;
    logic                            lsu_we;
    logic [1:0]                      lsu_size;
    logic                            lsu_sign_ext;
    logic                            branch_in_ex;
    logic                            illegal_insn;
    logic [rv_isa_pkg::XLEN-1:0]     pc;
  } id_ex_t;

  // Decoder output, consumed inside the stage only
  typedef struct packed {
    logic                            alu_en;
    rv_isa_pkg::alu_op_e             alu_op;
    logic                            rf_we;
    rv_isa_pkg::reg_addr_t           rf_waddr;
    logic                            rf_re_a;
    logic                            rf_re_b;
    logic                            lsu_en;
    logic                            lsu_we;
    logic [1:0]                      lsu_size;
    logic                            lsu_sign_ext;
    logic                            illegal_insn;
    rv_isa_pkg::op_a_sel_e           op_a_sel;
    rv_isa_pkg::op_b_sel_e           op_b_sel;
    rv_isa_pkg::imm_sel_e            imm_sel;
    logic                            is_jalr;
    logic                            is_branch;
    logic [rv_isa_pkg::XLEN-1:0]     imm_i;
    logic [rv_isa_pkg::XLEN-1:0]     imm_s;
    logic [rv_isa_pkg::XLEN-1:0]     imm_b;
    logic [rv_isa_pkg::XLEN-1:0]     imm_u;
    logic [rv_isa_pkg::XLEN-1:0]     imm_j;
  } decode_t;

endpackage

// File: hw/id_stage.sv
/*
  RV32I decode stage top. The register file sits outside the stage;
  read addresses and enables follow the IF/ID input in the same cycle.
*/
module id_stage (
  input  logic                          clk,
  input  logic                          rst_n,
  input  id_pipe_pkg::if_id_t           if_id_i,
  input  id_pipe_pkg::byp_ctrl_t        byp_ctrl_i,
  input  id_pipe_pkg::ctrl_fsm_t        ctrl_fsm_i,
  input  logic [rv_isa_pkg::XLEN-1:0]   rf_rdata_a_i,
  input  logic [rv_isa_pkg::XLEN-1:0]   rf_rdata_b_i,
  input  logic [rv_isa_pkg::XLEN-1:0]   rf_wdata_ex_i,
  input  logic [rv_isa_pkg::XLEN-1:0]   rf_wdata_wb_i,
  input  logic                          ex_ready_i,
  output rv_isa_pkg::reg_addr_t         rf_raddr_a_o,
  output rv_isa_pkg::reg_addr_t         rf_raddr_b_o,
  output logic                          rf_re_a_o,
  output logic                          rf_re_b_o,
  output logic [rv_isa_pkg::XLEN-1:0]   jmp_target_o,
  output id_pipe_pkg::id_ex_t           id_ex_o,
  output logic                          id_ready_o
);

  id_pipe_pkg::decode_t        dec;
  logic [rv_isa_pkg::XLEN-1:0] alu_operand_a;
  logic [rv_isa_pkg::XLEN-1:0] alu_operand_b;
  logic [rv_isa_pkg::XLEN-1:0] operand_c;

  // Source register addresses
  assign rf_raddr_a_o = if_id_i.instr[rv_isa_pkg::RS1_MSB:rv_isa_pkg::RS1_LSB];
  assign rf_raddr_b_o = if_id_i.instr[rv_isa_pkg::RS2_MSB:rv_isa_pkg::RS2_LSB];
  assign rf_re_a_o    = dec.rf_re_a;
  assign rf_re_b_o    = dec.rf_re_b;

  instr_decoder i_instr_decoder (
    .instr_i (if_id_i.instr),
    .dec_o   (dec)
  );

  operand_select i_operand_select (
    .dec_i           (dec),
    .pc_i            (if_id_i.pc),
    .byp_ctrl_i      (byp_ctrl_i),
    .rf_rdata_a_i    (rf_rdata_a_i),
    .rf_rdata_b_i    (rf_rdata_b_i),
    .rf_wdata_ex_i   (rf_wdata_ex_i),
    .rf_wdata_wb_i   (rf_wdata_wb_i),
    .alu_operand_a_o (alu_operand_a),
    .alu_operand_b_o (alu_operand_b),
    .operand_c_o     (operand_c),
    .jmp_target_o    (jmp_target_o)
  );

  id_ex_register i_id_ex_register (
    .clk             (clk),
    .rst_n           (rst_n),
    .if_id_i         (if_id_i),
    .ctrl_fsm_i      (ctrl_fsm_i),
    .ex_ready_i      (ex_ready_i),
    .dec_i           (dec),
    .alu_operand_a_i (alu_operand_a),
    .alu_operand_b_i (alu_operand_b),
    .operand_c_i     (operand_c),
    .id_ex_o         (id_ex_o),
    .id_ready_o      (id_ready_o)
  );

endmodule

// File: hw/instr_decoder.sv
/*
  Combinational RV32I decoder; any opcode or funct field outside the base
  set is flagged illegal and loses its register write and memory access.
*/
module instr_decoder (
  input  logic [31:0]          instr_i,
  output id_pipe_pkg::decode_t dec_o
);

  rv_isa_pkg::opcode_e opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic                is_reg;

  assign opcode = rv_isa_pkg::opcode_e'(instr_i[rv_isa_pkg::OPCODE_MSB:rv_isa_pkg::OPCODE_LSB]);
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];
  assign is_reg = (opcode == rv_isa_pkg::OPC_OP);

  ////////////////////////////////////////
  // Immediates, all sign extended
  ////////////////////////////////////////
  assign dec_o.imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign dec_o.imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign dec_o.imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                        instr_i[11:8], 1'b0};
  assign dec_o.imm_u = {instr_i[31:12], 12'b0};
  assign dec_o.imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                        instr_i[30:21], 1'b0};

  assign dec_o.rf_waddr = instr_i[rv_isa_pkg::RD_MSB:rv_isa_pkg::RD_LSB];

  ////////////////////////////////////////
  // Control decode
  ////////////////////////////////////////
  always_comb begin
    dec_o.alu_en       = 1'b1;
    dec_o.alu_op       = rv_isa_pkg::ALU_ADD;
    dec_o.op_a_sel     = rv_isa_pkg::OP_A_REG;
    dec_o.op_b_sel     = rv_isa_pkg::OP_B_IMM;
    dec_o.imm_sel      = rv_isa_pkg::IMM_I;
    dec_o.rf_we        = 1'b0;
    dec_o.rf_re_a      = 1'b0;
    dec_o.rf_re_b      = 1'b0;
    dec_o.lsu_en       = 1'b0;
    dec_o.lsu_we       = 1'b0;
    // Size and sign follow funct3 directly for loads and stores
    dec_o.lsu_size     = funct3[1:0];
    dec_o.lsu_sign_ext = !funct3[2];
    dec_o.is_jalr      = 1'b0;
    dec_o.is_branch    = 1'b0;
    dec_o.illegal_insn = 1'b0;

    unique case (opcode)
      rv_isa_pkg::OPC_OP, rv_isa_pkg::OPC_OP_IMM: begin
        dec_o.rf_we    = 1'b1;
        dec_o.rf_re_a  = 1'b1;
        dec_o.rf_re_b  = is_reg;
        dec_o.op_b_sel = is_reg ? rv_isa_pkg::OP_B_REG : rv_isa_pkg::OP_B_IMM;
        unique case (funct3)
          3'b000:  dec_o.alu_op = (is_reg && funct7[5]) ? rv_isa_pkg::ALU_SUB : rv_isa_pkg::ALU_ADD;
          3'b001:  dec_o.alu_op = rv_isa_pkg::ALU_SLL;
          3'b010:  dec_o.alu_op = rv_isa_pkg::ALU_SLT;
          3'b011:  dec_o.alu_op = rv_isa_pkg::ALU_SLTU;
          3'b100:  dec_o.alu_op = rv_isa_pkg::ALU_XOR;
          3'b101:  dec_o.alu_op = funct7[5] ? rv_isa_pkg::ALU_SRA : rv_isa_pkg::ALU_SRL;
          3'b110:  dec_o.alu_op = rv_isa_pkg::ALU_OR;
          default: dec_o.alu_op = rv_isa_pkg::ALU_AND;
        endcase
        // funct7 may only be 0x20 for SUB and SRA/SRAI; shifts by immediate check it too
        if (is_reg || funct3 == 3'b001 || funct3 == 3'b101) begin
          dec_o.illegal_insn = !((funct7 == 7'h00) ||
            (funct7 == 7'h20 && (funct3 == 3'b101 || (is_reg && funct3 == 3'b000))));
        end
      end
      rv_isa_pkg::OPC_LUI, rv_isa_pkg::OPC_AUIPC: begin
        dec_o.rf_we    = 1'b1;
        dec_o.imm_sel  = rv_isa_pkg::IMM_U;
        dec_o.op_a_sel = (opcode == rv_isa_pkg::OPC_LUI) ? rv_isa_pkg::OP_A_ZERO :
                                                           rv_isa_pkg::OP_A_PC;
      end
      rv_isa_pkg::OPC_JAL, rv_isa_pkg::OPC_JALR: begin
        // ALU produces the link address PC + 4
        dec_o.rf_we        = 1'b1;
        dec_o.op_a_sel     = rv_isa_pkg::OP_A_PC;
        dec_o.op_b_sel     = rv_isa_pkg::OP_B_PCINCR;
        dec_o.imm_sel      = rv_isa_pkg::IMM_J;
        dec_o.is_jalr      = (opcode == rv_isa_pkg::OPC_JALR);
        dec_o.rf_re_a      = dec_o.is_jalr;
        dec_o.illegal_insn = dec_o.is_jalr && (funct3 != 3'b000);
      end
      rv_isa_pkg::OPC_BRANCH: begin
        dec_o.rf_re_a   = 1'b1;
        dec_o.rf_re_b   = 1'b1;
        dec_o.is_branch = 1'b1;
        dec_o.op_b_sel  = rv_isa_pkg::OP_B_REG;
        dec_o.imm_sel   = rv_isa_pkg::IMM_B;
        unique case (funct3)
          3'b000:  dec_o.alu_op = rv_isa_pkg::ALU_EQ;
          3'b001:  dec_o.alu_op = rv_isa_pkg::ALU_NE;
          3'b100:  dec_o.alu_op = rv_isa_pkg::ALU_LT;
          3'b101:  dec_o.alu_op = rv_isa_pkg::ALU_GE;
          3'b110:  dec_o.alu_op = rv_isa_pkg::ALU_LTU;
          3'b111:  dec_o.alu_op = rv_isa_pkg::ALU_GEU;
          default: dec_o.illegal_insn = 1'b1;
        endcase
      end
      rv_isa_pkg::OPC_LOAD: begin
        dec_o.rf_we        = 1'b1;
        dec_o.rf_re_a      = 1'b1;
        dec_o.lsu_en       = 1'b1;
        // LB LH LW LBU LHU only
        dec_o.illegal_insn = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
      end
      rv_isa_pkg::OPC_STORE: begin
        dec_o.rf_re_a      = 1'b1;
        dec_o.rf_re_b      = 1'b1;
        dec_o.lsu_en       = 1'b1;
        dec_o.lsu_we       = 1'b1;
        dec_o.imm_sel      = rv_isa_pkg::IMM_S;
        dec_o.illegal_insn = funct3[2] || (funct3[1:0] == 2'b11);
      end
      default: begin
        dec_o.alu_en       = 1'b0;
        dec_o.illegal_insn = 1'b1;
      end
    endcase

    // Illegal instructions must not change architectural state
    if (dec_o.illegal_insn) begin
      dec_o.rf_we  = 1'b0;
      dec_o.lsu_en = 1'b0;
    end
  end

endmodule

// File: hw/operand_select.sv
/*
  Operand forwarding and selection for the ID/EX record, plus jump target.
  Purely combinational; forward selects come straight from the controller.
*/
module operand_select (
  input  id_pipe_pkg::decode_t          dec_i,
  input  logic [rv_isa_pkg::XLEN-1:0]   pc_i,
  input  id_pipe_pkg::byp_ctrl_t        byp_ctrl_i,
  input  logic [rv_isa_pkg::XLEN-1:0]   rf_rdata_a_i,
  input  logic [rv_isa_pkg::XLEN-1:0]   rf_rdata_b_i,
  input  logic [rv_isa_pkg::XLEN-1:0]   rf_wdata_ex_i,
  input  logic [rv_isa_pkg::XLEN-1:0]   rf_wdata_wb_i,
  output logic [rv_isa_pkg::XLEN-1:0]   alu_operand_a_o,
  output logic [rv_isa_pkg::XLEN-1:0]   alu_operand_b_o,
  output logic [rv_isa_pkg::XLEN-1:0]   operand_c_o,
  output logic [rv_isa_pkg::XLEN-1:0]   jmp_target_o
);

  logic [rv_isa_pkg::XLEN-1:0] operand_a_fw;
  logic [rv_isa_pkg::XLEN-1:0] operand_b_fw;
  logic [rv_isa_pkg::XLEN-1:0] imm;
  logic [rv_isa_pkg::XLEN-1:0] bch_target;
  logic                        is_jal;

  // Same forwarding mux for both source ports
  function automatic logic [rv_isa_pkg::XLEN-1:0] fw_mux(
    input id_pipe_pkg::fw_sel_e        sel,
    input logic [rv_isa_pkg::XLEN-1:0] rf_data,
    input logic [rv_isa_pkg::XLEN-1:0] ex_data,
    input logic [rv_isa_pkg::XLEN-1:0] wb_data
  );
    case (sel)
      id_pipe_pkg::FW_EX: return ex_data;
      id_pipe_pkg::FW_WB: return wb_data;
      default:            return rf_data;
    endcase
  endfunction

  assign operand_a_fw = fw_mux(byp_ctrl_i.operand_a_sel, rf_rdata_a_i, rf_wdata_ex_i,
                               rf_wdata_wb_i);
  assign operand_b_fw = fw_mux(byp_ctrl_i.operand_b_sel, rf_rdata_b_i, rf_wdata_ex_i,
                               rf_wdata_wb_i);

  ////////////////////////////////////////
  // Operand A and B
  ////////////////////////////////////////
  always_comb begin
    case (dec_i.op_a_sel)
      rv_isa_pkg::OP_A_PC:   alu_operand_a_o = pc_i;
      rv_isa_pkg::OP_A_ZERO: alu_operand_a_o = '0;
      default:               alu_operand_a_o = operand_a_fw;
    endcase
  end

  always_comb begin
    case (dec_i.imm_sel)
      rv_isa_pkg::IMM_S: imm = dec_i.imm_s;
      rv_isa_pkg::IMM_B: imm = dec_i.imm_b;
      rv_isa_pkg::IMM_U: imm = dec_i.imm_u;
      rv_isa_pkg::IMM_J: imm = dec_i.imm_j;
      default:           imm = dec_i.imm_i;
    endcase
  end

  always_comb begin
    case (dec_i.op_b_sel)
      rv_isa_pkg::OP_B_IMM:    alu_operand_b_o = imm;
      rv_isa_pkg::OP_B_PCINCR: alu_operand_b_o = rv_isa_pkg::PC_INCR;
      default:                 alu_operand_b_o = operand_b_fw;
    endcase
  end

  ////////////////////////////////////////
  // Operand C and control transfer targets
  ////////////////////////////////////////
  assign bch_target = pc_i + dec_i.imm_b;

  // Store data or branch target travel in operand C
  assign operand_c_o = (dec_i.lsu_en && dec_i.lsu_we) ? operand_b_fw :
                       dec_i.is_branch                ? bch_target   : '0;

  // JAL is the only link instruction that is not JALR
  assign is_jal = (dec_i.op_b_sel == rv_isa_pkg::OP_B_PCINCR) && !dec_i.is_jalr;

  always_comb begin
    if (dec_i.is_jalr) begin
      jmp_target_o = (operand_a_fw + dec_i.imm_i) & ~32'd1;
    end else if (is_jal) begin
      jmp_target_o = pc_i + dec_i.imm_j;
    end else begin
      jmp_target_o = bch_target;
    end
  end

endmodule

// File: hw/rv_isa_pkg.sv
/*
  RV32I base integer encodings used by the decode stage.
  Only uncompressed 32-bit instructions are covered; no M, A, CSR or system opcodes.
*/
package rv_isa_pkg;

  // Data path and PC width
  localparam int unsigned XLEN = 32;

  typedef logic [4:0] reg_addr_t;

  // Field positions inside the instruction word
  localparam int unsigned RS1_MSB    = 19;
  localparam int unsigned RS1_LSB    = 15;
  localparam int unsigned RS2_MSB    = 24;
  localparam int unsigned RS2_LSB    = 20;
  localparam int unsigned RD_MSB     = 11;
  localparam int unsigned RD_LSB     = 7;
  localparam int unsigned OPCODE_MSB = 6;
  localparam int unsigned OPCODE_LSB = 0;

  // Link address step, no compressed support
  localparam logic [XLEN-1:0] PC_INCR = 32'd4;

  ////////////////////////////////////////
  // Major opcodes
  ////////////////////////////////////////
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011
  } opcode_e;

  // ALU operations, branch compares share the same encoding space
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
    ALU_OR, ALU_AND, ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  ////////////////////////////////////////
  // Operand and immediate selects
  ////////////////////////////////////////
  typedef enum logic [1:0] {OP_A_REG, OP_A_PC, OP_A_ZERO} op_a_sel_e;

  typedef enum logic [1:0] {OP_B_REG, OP_B_IMM, OP_B_PCINCR} op_b_sel_e;

  typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_sel_e;

endpackage

// File: tb.f
hw/rv_isa_pkg.sv
hw/id_pipe_pkg.sv
hw/instr_decoder.sv
hw/operand_select.sv
hw/id_ex_register.sv
hw/id_stage.sv
tests/id_stage_tb.sv

// File: tests/id_stage_tb.sv
/*
  Directed testbench for the RV32I decode stage, one instruction per step.
  Register data, forward data and PCs are random from a fixed seed.
*/
module id_stage_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned SEED           = 32'hf73f6414;
  // About 30 cycles of stimulus, the watchdog allows five times the rounded figure
  localparam int unsigned TEST_CYCLES    = 40;
  localparam int unsigned TIMEOUT_CYCLES = 5 * TEST_CYCLES;

  // Major opcodes as the ISA manual lists them
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  logic                   clk;
  logic                   rst_n;
  id_pipe_pkg::if_id_t    if_id;
  id_pipe_pkg::byp_ctrl_t byp_ctrl;
  id_pipe_pkg::ctrl_fsm_t ctrl_fsm;
  logic [31:0]            rf_rdata_a;
  logic [31:0]            rf_rdata_b;
  logic [31:0]            rf_wdata_ex;
  logic [31:0]            rf_wdata_wb;
  logic                   ex_ready;
  rv_isa_pkg::reg_addr_t  rf_raddr_a;
  rv_isa_pkg::reg_addr_t  rf_raddr_b;
  logic                   rf_re_a;
  logic                   rf_re_b;
  logic [31:0]            jmp_target;
  id_pipe_pkg::id_ex_t    id_ex;
  logic                   id_ready;

  // Controls that go out with the next instruction
  logic                   ready_next;
  logic                   halt_next;
  logic                   kill_next;
  id_pipe_pkg::byp_ctrl_t byp_next;
  // PC and combinational outputs seen before the edge
  logic [31:0]            cur_pc;
  logic [31:0]            jmp_seen;
  logic                   ready_seen;
  rv_isa_pkg::reg_addr_t  raddr_a_seen;
  rv_isa_pkg::reg_addr_t  raddr_b_seen;
  logic                   re_a_seen;
  logic                   re_b_seen;
  int                     errors;

  id_stage i_id_stage (
    .clk           (clk),
    .rst_n         (rst_n),
    .if_id_i       (if_id),
    .byp_ctrl_i    (byp_ctrl),
    .ctrl_fsm_i    (ctrl_fsm),
    .rf_rdata_a_i  (rf_rdata_a),
    .rf_rdata_b_i  (rf_rdata_b),
    .rf_wdata_ex_i (rf_wdata_ex),
    .rf_wdata_wb_i (rf_wdata_wb),
    .ex_ready_i    (ex_ready),
    .rf_raddr_a_o  (rf_raddr_a),
    .rf_raddr_b_o  (rf_raddr_b),
    .rf_re_a_o     (rf_re_a),
    .rf_re_b_o     (rf_re_b),
    .jmp_target_o  (jmp_target),
    .id_ex_o       (id_ex),
    .id_ready_o    (id_ready)
  );

  always #2 clk = ~clk;

  ////////////////////////////////////////
  // Instruction encoders
  ////////////////////////////////////////
  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] i_type(input logic [31:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm[11:0], rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] s_type(input logic [31:0] imm, input logic [4:0] rs2, rs1,
                                         input logic [2:0] f3, input logic [6:0] opc);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], opc};
  endfunction

  // Branch offsets are scrambled, bit 0 is implied
  function automatic logic [31:0] b_type(input logic [31:0] imm, input logic [4:0] rs2, rs1,
                                         input logic [2:0] f3, input logic [6:0] opc);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc};
  endfunction

  function automatic logic [31:0] u_type(input logic [31:0] imm, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm[31:12], rd, opc};
  endfunction

  function automatic logic [31:0] j_type(input logic [31:0] imm, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc};
  endfunction

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////
  task automatic compare_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
    assert (act === exp) else begin
      $display("ERROR %s: expected %08h, actual %08h", name, exp, act);
      errors++;
    end
  endtask

  task automatic compare_flag(input string name, input logic exp, input logic act);
    assert (act === exp) else begin
      $display("ERROR %s: expected %0b, actual %0b", name, exp, act);
      errors++;
    end
  endtask

  task automatic compare_record(input string name, input id_pipe_pkg::id_ex_t exp,
                                input id_pipe_pkg::id_ex_t act);
    assert (act === exp) else begin
      $display("ERROR %s: expected %0h, actual %0h", name, exp, act);
      errors++;
    end
  endtask

  task automatic alu_fields(input string name, input rv_isa_pkg::alu_op_e op,
                            input logic [31:0] a, input logic [31:0] b);
    compare_flag({name, " alu_en"}, 1'b1, id_ex.alu_en);
    compare_word({name, " alu_op"}, 32'(op), 32'(id_ex.alu_op));
    compare_word({name, " operand_a"}, a, id_ex.alu_operand_a);
    compare_word({name, " operand_b"}, b, id_ex.alu_operand_b);
  endtask

  // Record must be valid and carry its PC; rd only matters when it writes
  task automatic writeback_fields(input string name, input logic we, input logic [4:0] rd);
    compare_flag({name, " instr_valid"}, 1'b1, id_ex.instr_valid);
    compare_word({name, " pc"}, cur_pc, id_ex.pc);
    compare_flag({name, " rf_we"}, we, id_ex.rf_we);
    if (we) begin
      compare_word({name, " rf_waddr"}, 32'(rd), 32'(id_ex.rf_waddr));
    end
  endtask

  task automatic memory_fields(input string name, input logic we, input logic [1:0] size,
                               input logic sign);
    compare_flag({name, " lsu_en"}, 1'b1, id_ex.lsu_en);
    compare_flag({name, " lsu_we"}, we, id_ex.lsu_we);
    compare_word({name, " lsu_size"}, 32'(size), 32'(id_ex.lsu_size));
    if (!we) begin
      compare_flag({name, " lsu_sign_ext"}, sign, id_ex.lsu_sign_ext);
    end
  endtask

  // Register file read enables, and the address of each source that is read
  task automatic read_ports(input string name, input logic re_a, input logic re_b,
                            input logic [4:0] rs1, input logic [4:0] rs2);
    compare_flag({name, " rf_re_a"}, re_a, re_a_seen);
    compare_flag({name, " rf_re_b"}, re_b, re_b_seen);
    if (re_a) begin
      compare_word({name, " rf_raddr_a"}, 32'(rs1), 32'(raddr_a_seen));
    end
    if (re_b) begin
      compare_word({name, " rf_raddr_b"}, 32'(rs2), 32'(raddr_b_seen));
    end
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////
  // Drive on the falling edge, sample just after the next rising edge
  task automatic issue_instr(input logic [31:0] instr);
    @(negedge clk);
    cur_pc            = $urandom & 32'hffff_fffc;
    rf_rdata_a        = $urandom;
    rf_rdata_b        = $urandom;
    rf_wdata_ex       = $urandom;
    rf_wdata_wb       = $urandom;
    if_id.instr_valid = 1'b1;
    if_id.pc          = cur_pc;
    if_id.instr       = instr;
    byp_ctrl          = byp_next;
    ctrl_fsm.halt_id  = halt_next;
    ctrl_fsm.kill_id  = kill_next;
    ex_ready          = ready_next;
    // Combinational outputs settle well before the rising edge
    #1;
    jmp_seen     = jmp_target;
    ready_seen   = id_ready;
    raddr_a_seen = rf_raddr_a;
    raddr_b_seen = rf_raddr_b;
    re_a_seen    = rf_re_a;
    re_b_seen    = rf_re_b;
    @(posedge clk);
    #1;
  endtask

  task automatic reset_and_alu();
    compare_flag("reset instr_valid", 1'b0, id_ex.instr_valid);
    compare_flag("reset rf_we", 1'b0, id_ex.rf_we);
    compare_flag("reset lsu_en", 1'b0, id_ex.lsu_en);
    compare_flag("reset alu_en", 1'b0, id_ex.alu_en);
    compare_flag("reset branch_in_ex", 1'b0, id_ex.branch_in_ex);
    compare_flag("reset illegal_insn", 1'b0, id_ex.illegal_insn);
    issue_instr(i_type(32'hffff_ffef, 5'd3, 3'b000, 5'd5, OPC_OP_IMM));
    alu_fields("addi", rv_isa_pkg::ALU_ADD, rf_rdata_a, 32'hffff_ffef);
    writeback_fields("addi", 1'b1, 5'd5);
    read_ports("addi", 1'b1, 1'b0, 5'd3, 5'd0);
    compare_flag("addi id_ready", 1'b1, ready_seen);
    issue_instr(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd7, OPC_OP));
    alu_fields("sub", rv_isa_pkg::ALU_SUB, rf_rdata_a, rf_rdata_b);
    writeback_fields("sub", 1'b1, 5'd7);
    read_ports("sub", 1'b1, 1'b1, 5'd1, 5'd2);
    issue_instr(r_type(7'h00, 5'd9, 5'd4, 3'b011, 5'd8, OPC_OP));
    alu_fields("sltu", rv_isa_pkg::ALU_SLTU, rf_rdata_a, rf_rdata_b);
    writeback_fields("sltu", 1'b1, 5'd8);
    // LUI adds its immediate to zero, AUIPC to the PC
    issue_instr(u_type(32'habcd_e000, 5'd10, OPC_LUI));
    alu_fields("lui", rv_isa_pkg::ALU_ADD, 32'd0, 32'habcd_e000);
    writeback_fields("lui", 1'b1, 5'd10);
    read_ports("lui", 1'b0, 1'b0, 5'd0, 5'd0);
    issue_instr(u_type(32'h8000_1000, 5'd11, OPC_AUIPC));
    alu_fields("auipc", rv_isa_pkg::ALU_ADD, cur_pc, 32'h8000_1000);
    writeback_fields("auipc", 1'b1, 5'd11);
  endtask

  task automatic forwarding();
    byp_next.operand_a_sel = id_pipe_pkg::FW_EX;
    byp_next.operand_b_sel = id_pipe_pkg::FW_WB;
    issue_instr(r_type(7'h00, 5'd6, 5'd5, 3'b000, 5'd4, OPC_OP));
    alu_fields("add fw ex/wb", rv_isa_pkg::ALU_ADD, rf_wdata_ex, rf_wdata_wb);
    byp_next.operand_a_sel = id_pipe_pkg::FW_WB;
    byp_next.operand_b_sel = id_pipe_pkg::FW_EX;
    issue_instr(r_type(7'h00, 5'd6, 5'd5, 3'b111, 5'd4, OPC_OP));
    alu_fields("and fw wb/ex", rv_isa_pkg::ALU_AND, rf_wdata_wb, rf_wdata_ex);
    byp_next = '0;
  endtask

  task automatic load_store();
    issue_instr(i_type(32'd40, 5'd2, 3'b010, 5'd12, OPC_LOAD));
    alu_fields("lw", rv_isa_pkg::ALU_ADD, rf_rdata_a, 32'd40);
    writeback_fields("lw", 1'b1, 5'd12);
    memory_fields("lw", 1'b0, 2'd2, 1'b1);
    read_ports("lw", 1'b1, 1'b0, 5'd2, 5'd0);
    issue_instr(i_type(32'hffff_fffc, 5'd6, 3'b100, 5'd13, OPC_LOAD));
    alu_fields("lbu", rv_isa_pkg::ALU_ADD, rf_rdata_a, 32'hffff_fffc);
    memory_fields("lbu", 1'b0, 2'd0, 1'b0);
    issue_instr(s_type(32'hffff_ff9c, 5'd14, 5'd15, 3'b010, OPC_STORE));
    alu_fields("sw", rv_isa_pkg::ALU_ADD, rf_rdata_a, 32'hffff_ff9c);
    writeback_fields("sw", 1'b0, 5'd0);
    memory_fields("sw", 1'b1, 2'd2, 1'b0);
    read_ports("sw", 1'b1, 1'b1, 5'd15, 5'd14);
    compare_word("sw operand_c", rf_rdata_b, id_ex.operand_c);
  endtask

  task automatic jumps_branches();
    // Negative J offset exercises the sign bit
    issue_instr(j_type(32'hfff0_0800, 5'd1, OPC_JAL));
    compare_word("jal target", cur_pc + 32'hfff0_0800, jmp_seen);
    alu_fields("jal", rv_isa_pkg::ALU_ADD, cur_pc, 32'd4);
    writeback_fields("jal", 1'b1, 5'd1);
    read_ports("jal", 1'b0, 1'b0, 5'd0, 5'd0);
    issue_instr(i_type(32'd13, 5'd5, 3'b000, 5'd1, OPC_JALR));
    compare_word("jalr target", (rf_rdata_a + 32'd13) & 32'hffff_fffe, jmp_seen);
    alu_fields("jalr", rv_isa_pkg::ALU_ADD, cur_pc, 32'd4);
    writeback_fields("jalr", 1'b1, 5'd1);
    read_ports("jalr", 1'b1, 1'b0, 5'd5, 5'd0);
    issue_instr(b_type(32'hffff_ffc0, 5'd4, 5'd3, 3'b000, OPC_BRANCH));
    compare_word("beq operand_c", cur_pc + 32'hffff_ffc0, id_ex.operand_c);
    compare_flag("beq branch_in_ex", 1'b1, id_ex.branch_in_ex);
    compare_word("beq alu_op", 32'(rv_isa_pkg::ALU_EQ), 32'(id_ex.alu_op));
    writeback_fields("beq", 1'b0, 5'd0);
    read_ports("beq", 1'b1, 1'b1, 5'd3, 5'd4);
  endtask

  task automatic stall_halt_kill();
    id_pipe_pkg::id_ex_t held;
    issue_instr(i_type(32'd1, 5'd1, 3'b000, 5'd2, OPC_OP_IMM));
    held = id_ex;
    // Back-pressure freezes the whole record
    ready_next = 1'b0;
    issue_instr(i_type(32'd2, 5'd3, 3'b000, 5'd4, OPC_OP_IMM));
    compare_flag("stall id_ready", 1'b0, ready_seen);
    compare_record("stall hold", held, id_ex);
    ready_next = 1'b1;
    halt_next  = 1'b1;
    issue_instr(i_type(32'd3, 5'd3, 3'b000, 5'd4, OPC_OP_IMM));
    compare_flag("halt id_ready", 1'b0, ready_seen);
    compare_flag("halt instr_valid", 1'b0, id_ex.instr_valid);
    compare_word("halt pc kept", held.pc, id_ex.pc);
    halt_next = 1'b0;
    issue_instr(i_type(32'd4, 5'd3, 3'b000, 5'd4, OPC_OP_IMM));
    writeback_fields("after halt", 1'b1, 5'd4);
    // Kill frees ID even while EX holds the record
    held       = id_ex;
    ready_next = 1'b0;
    kill_next  = 1'b1;
    issue_instr(i_type(32'd5, 5'd3, 3'b000, 5'd4, OPC_OP_IMM));
    compare_flag("kill stall id_ready", 1'b1, ready_seen);
    compare_record("kill stall hold", held, id_ex);
    ready_next = 1'b1;
    issue_instr(i_type(32'd6, 5'd3, 3'b000, 5'd4, OPC_OP_IMM));
    compare_flag("kill id_ready", 1'b1, ready_seen);
    compare_flag("kill instr_valid", 1'b0, id_ex.instr_valid);
    kill_next = 1'b0;
  endtask

  task automatic illegal_opcode();
    issue_instr(i_type(32'd0, 5'd0, 3'b000, 5'd3, OPC_SYSTEM));
    compare_flag("system illegal_insn", 1'b1, id_ex.illegal_insn);
    compare_flag("system alu_en", 1'b0, id_ex.alu_en);
    writeback_fields("system", 1'b0, 5'd0);
    compare_flag("system lsu_en", 1'b0, id_ex.lsu_en);
    read_ports("system", 1'b0, 1'b0, 5'd0, 5'd0);
    // LD is RV64 only
    issue_instr(i_type(32'd0, 5'd1, 3'b011, 5'd2, OPC_LOAD));
    compare_flag("ld illegal_insn", 1'b1, id_ex.illegal_insn);
    writeback_fields("ld", 1'b0, 5'd0);
    compare_flag("ld lsu_en", 1'b0, id_ex.lsu_en);
  endtask

  ////////////////////////////////////////
  // Run control
  ////////////////////////////////////////
  initial begin
    void'($urandom(SEED));
    errors      = 0;
    clk         = 1'b0;
    rst_n       = 1'b0;
    if_id       = '0;
    byp_ctrl    = '0;
    ctrl_fsm    = '0;
    rf_rdata_a  = '0;
    rf_rdata_b  = '0;
    rf_wdata_ex = '0;
    rf_wdata_wb = '0;
    ex_ready    = 1'b0;
    ready_next  = 1'b1;
    halt_next   = 1'b0;
    kill_next   = 1'b0;
    byp_next    = '0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    reset_and_alu();
    forwarding();
    load_store();
    jumps_branches();
    stall_halt_kill();
    illegal_opcode();
    $display("Checks done with %0d errors", errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Timeout: tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule
